/* sources.f */
src/tart_pkg.sv
src/fake_antenna.sv
src/capture_front.sv
src/block_buffer.sv
src/acq_control.sv
src/mcb_writer.sv
src/tart_capture.sv
testbench/clock_gen.sv
testbench/tb_tart_capture.sv

/* testbench/tb_tart_capture.sv */
`default_nettype none

module tb_tart_capture;
   timeunit 1ns;
   timeprecision 100ps;
   import tart_pkg::*;

   localparam int               AXNUM     = 24;
   localparam int               ABITS     = 6;
   localparam int               NWORDS    = 2 ** ABITS;  // Four blocks
   localparam int               BLK_WORDS = 16;
   localparam logic [AXNUM-1:0] SEED      = 24'h00ace1;
   localparam int               NROWS     = 7;

   typedef enum logic [1:0] {RDY_ALWAYS, RDY_RANDOM, RDY_STALL} rdy_mode_t;

   typedef struct packed {
      logic             debug;  // Fake source
      logic [AXNUM-1:0] word;   // Constant on the antennas
      logic [2:0]       delay;
      rdy_mode_t        mode;
   } row_t;

   // -------------------------------------------------------------------
   // Stimulus table
   // -------------------------------------------------------------------
   row_t table_rows [NROWS] = '{
      '{1'b0, 24'h5a3c96, 3'd0, RDY_ALWAYS},
      '{1'b1, 24'hffffff, 3'd2, RDY_ALWAYS},
      '{1'b1, 24'hffffff, 3'd5, RDY_ALWAYS},
      '{1'b1, 24'hffffff, 3'd7, RDY_ALWAYS},  // Clamped to 5
      '{1'b0, 24'hc3a50f, 3'd3, RDY_RANDOM},
      '{1'b0, 24'h0f0f0f, 3'd1, RDY_STALL},
      '{1'b0, 24'h123456, 3'd4, RDY_ALWAYS}   // Address restarts after overflow
   };

   logic                  clk;
   logic                  rst;
   logic [AXNUM-1:0]      ax_data;
   logic                  aq_debug;
   logic [PHASE_BITS-1:0] aq_delay;
   logic                  aq_ce;
   logic                  rd_req;
   logic                  mcb_rdy;
   logic [AXNUM-1:0]      ax_data_out;
   logic                  mcb_ce;
   logic                  mcb_wr;
   logic [ABITS-1:0]      mcb_adr;
   logic [MCB_DW-1:0]     mcb_dat;
   tart_state_t           tart_state;

   rdy_mode_t             rdy_mode;
   logic [15:0]           rand_q = 16'd78;
   logic [ABITS-1:0]      adr_seen [$];  // Accepted writes, in order
   logic [MCB_DW-1:0]     dat_seen [$];
   int                    checks = 0;
   int                    errors = 0;

   clock_gen #(.PERIOD(8), .RESET_CYCLES(3)) clk0 (.clk_o(clk), .rst_o(rst));

   tart_capture #(.AXNUM(AXNUM), .BBITS(4), .ABITS(ABITS), .FAKE_SEED(SEED)) dut0 (
      .clk_i        (clk),
      .rst_i        (rst),
      .ax_data_i    (ax_data),
      .aq_debug_i   (aq_debug),
      .aq_delay_i   (aq_delay),
      .aq_ce_i      (aq_ce),
      .rd_req_i     (rd_req),
      .mcb_rdy_i    (mcb_rdy),
      .ax_data_o    (ax_data_out),
      .mcb_ce_o     (mcb_ce),
      .mcb_wr_o     (mcb_wr),
      .mcb_adr_o    (mcb_adr),
      .mcb_dat_o    (mcb_dat),
      .tart_state_o (tart_state)
   );

   // -------------------------------------------------------------------
   // Reference rules
   // -------------------------------------------------------------------
   // Ready pattern source, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // Fake antenna rule, taps 24 23 22 17, new bit at the LSB
   function automatic logic [AXNUM-1:0] fake_step(input logic [AXNUM-1:0] s);
      return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
   endfunction

   function automatic string mode_text(input rdy_mode_t m);
      case (m)
         RDY_ALWAYS: return "always";
         RDY_RANDOM: return "random";
         default:    return "stalled";
      endcase
   endfunction

   // -------------------------------------------------------------------
   // Memory port: ready driver and write monitor
   // -------------------------------------------------------------------
   always @(negedge clk) begin
      case (rdy_mode)
         RDY_ALWAYS: mcb_rdy = 1'b1;
         RDY_RANDOM: begin
            rand_q  = lfsr_next(rand_q);  // One step per bit taken
            mcb_rdy = rand_q[0];
         end
         default:    mcb_rdy = (adr_seen.size() == 0) || (tart_state == OVERFLOW);
      endcase
      if (mcb_wr !== mcb_ce) begin
         errors++;
         $display("error mcb_wr_o got %h expected %h at %0t", mcb_wr, mcb_ce, $time);
      end
      if (mcb_ce === 1'b1 && mcb_rdy) begin  // Accepted at the next rising edge
         adr_seen.push_back(mcb_adr);
         dat_seen.push_back(mcb_dat);
      end
   end

   // -------------------------------------------------------------------
   // Compare tasks
   // -------------------------------------------------------------------
   task automatic compare_word(input string name, input logic [AXNUM-1:0] got,
                               input logic [AXNUM-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_state(input string name, input tart_state_t got,
                                input tart_state_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_mem(input int idx, input logic [ABITS-1:0] got_adr,
                              input logic [MCB_DW-1:0] got_dat,
                              input logic [ABITS-1:0] exp_adr,
                              input logic [MCB_DW-1:0] exp_dat);
      checks++;
      if (got_adr !== exp_adr || got_dat !== exp_dat) begin
         errors++;
         $display("error mcb_adr_o/mcb_dat_o write %0d got %h/%h expected %h/%h",
                  idx, got_adr, got_dat, exp_adr, exp_dat);
      end
   endtask

   // -------------------------------------------------------------------
   // Waits
   // -------------------------------------------------------------------
   task automatic abort_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   task automatic wait_writes(input int n, input int limit);
      int cycles;
      cycles = 0;
      while (adr_seen.size() < n) begin
         if (cycles == limit) begin
            abort_on_timeout($sformatf("%0d memory writes", n));
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic wait_state(input tart_state_t st, input int limit);
      int cycles;
      cycles = 0;
      while (tart_state !== st) begin
         if (cycles == limit) begin
            abort_on_timeout($sformatf("tart_state_o %h", st));
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic wait_reset_release(input int limit);
      int cycles;
      cycles = 0;
      while (rst !== 1'b0) begin
         if (cycles == limit) begin
            abort_on_timeout("reset release");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   // -------------------------------------------------------------------
   // One table row, from idle back to idle
   // -------------------------------------------------------------------
   task automatic run_row(input int r, output bit ok);
      row_t             row;
      int               n_exp;
      int               err_start;
      int               i;
      logic [AXNUM-1:0] fake_s;
      logic [AXNUM-1:0] prev_word;
      row = table_rows[r];
      n_exp = (row.mode == RDY_STALL) ? BLK_WORDS : NWORDS;
      err_start = errors;
      adr_seen.delete();  // Writer idle here
      dat_seen.delete();
      rdy_mode = row.mode;
      prev_word = ax_data;
      ax_data = row.word;
      aq_debug = row.debug;
      aq_delay = row.delay;
      @(negedge clk);
      if (!row.debug) begin
         compare_word("ax_data_o", ax_data_out, prev_word);  // Still the old word
      end
      @(negedge clk);
      if (!row.debug) begin
         compare_word("ax_data_o", ax_data_out, row.word);  // Two-register real path
      end
      aq_ce = 1'b1;
      @(negedge clk);
      if (row.debug) begin
         compare_word("ax_data_o", ax_data_out, SEED);  // Seed loaded on start
      end
      if (row.mode == RDY_STALL) begin
         wait_state(OVERFLOW, 400);
         wait_writes(BLK_WORDS, 200);
         repeat (60) @(negedge clk);  // Nothing past the first block
         compare_state("tart_state_o", tart_state, OVERFLOW);
      end else begin
         wait_writes(NWORDS, 1500);
         wait_state(FULL, 100);
         repeat (100) @(negedge clk);
         compare_state("tart_state_o", tart_state, FULL);
      end
      if (adr_seen.size() != n_exp) begin
         errors++;
         $display("row %0d saw %0d memory writes where %0d were expected",
                  r, adr_seen.size(), n_exp);
      end
      fake_s = SEED;
      for (i = 0; i < adr_seen.size() && i < n_exp; i++) begin
         compare_mem(i, adr_seen[i], dat_seen[i], ABITS'(i),
                     MCB_DW'(row.debug ? fake_s : row.word));
         fake_s = fake_step(fake_s);
      end
      // Host read of the region
      aq_ce = 1'b0;
      rd_req = 1'b1;
      @(negedge clk);
      rd_req = 1'b0;
      compare_state("tart_state_o", tart_state, IDLE);
      compare_flag("mcb_ce_o", mcb_ce, 1'b0);
      ok = (errors == err_start);
      $display("row %0d debug %0d delay %0d ready %s writes %0d %s", r, row.debug,
               row.delay, mode_text(row.mode), adr_seen.size(), ok ? "ok" : "failed");
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial begin
      int r;
      int err_start;
      int passed;
      bit ok;
      ax_data = '0;
      aq_debug = 1'b0;
      aq_delay = '0;
      aq_ce = 1'b0;
      rd_req = 1'b0;
      mcb_rdy = 1'b1;
      rdy_mode = RDY_ALWAYS;
      passed = 0;

      wait_reset_release(20);
      err_start = errors;
      compare_flag("mcb_ce_o", mcb_ce, 1'b0);
      compare_flag("mcb_wr_o", mcb_wr, 1'b0);
      compare_state("tart_state_o", tart_state, IDLE);
      repeat (50) @(negedge clk);  // Enable low, port must stay quiet
      if (adr_seen.size() != 0) begin
         errors++;
         $display("memory writes happened while acquisition was disabled");
      end
      compare_state("tart_state_o", tart_state, IDLE);
      ok = (errors == err_start);
      passed += ok;
      $display("reset and idle %s", ok ? "ok" : "failed");

      for (r = 0; r < NROWS; r++) begin
         run_row(r, ok);
         passed += ok;
      end

      $display("tests %0d passed %0d failed %0d checks %0d errors %0d",
               NROWS + 1, passed, NROWS + 1 - passed, checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`default_nettype none

module clock_gen #(
   parameter int PERIOD       = 8,  // ns
   parameter int RESET_CYCLES = 3
) (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Synchronous reset, released on a falling edge
   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

/* src/tart_capture.sv */
`default_nettype none

module tart_capture #(
   parameter int               AXNUM     = 24,
   parameter int               BBITS     = 4,        // 16 samples per block
   parameter int               ABITS     = 20,       // Memory region of 2**ABITS words
   parameter logic [AXNUM-1:0] FAKE_SEED = 'h00ace1
) (
   input  wire logic                            clk_i,
   input  wire logic                            rst_i,
   input  wire logic [AXNUM-1:0]                ax_data_i,
   input  wire logic                            aq_debug_i,  // Fake source select
   input  wire logic [tart_pkg::PHASE_BITS-1:0] aq_delay_i,  // Sample phase
   input  wire logic                            aq_ce_i,
   input  wire logic                            rd_req_i,
   input  wire logic                            mcb_rdy_i,
   output logic      [AXNUM-1:0]                ax_data_o,
   output logic                                 mcb_ce_o,
   output logic                                 mcb_wr_o,
   output logic      [ABITS-1:0]                mcb_adr_o,
   output logic      [tart_pkg::MCB_DW-1:0]     mcb_dat_o,
   output tart_pkg::tart_state_t                tart_state_o
);

   logic [AXNUM-1:0] sample;
   logic             sample_stb;
   logic [AXNUM-1:0] fake;
   logic             fake_restart;

   // Buffer ports
   logic             wr_en;
   logic [BBITS:0]   wr_addr;
   logic [AXNUM-1:0] wr_data;
   logic [BBITS:0]   rd_addr;
   logic [AXNUM-1:0] rd_data;

   // Controller and writer hand-off
   logic             blk_ready;
   logic             blk_sel;
   logic             busy;
   logic             mem_full;

   // -------------------------------------------------------------------
   // Front end and debug source
   // -------------------------------------------------------------------
   fake_antenna #(.AXNUM(AXNUM), .FAKE_SEED(FAKE_SEED)) fake0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .step_i    (sample_stb),
      .restart_i (fake_restart),
      .fake_o    (fake)
   );

   capture_front #(.AXNUM(AXNUM)) front0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ax_data_i    (ax_data_i),
      .fake_i       (fake),
      .aq_debug_i   (aq_debug_i),
      .aq_delay_i   (aq_delay_i),
      .ax_data_o    (ax_data_o),
      .sample_o     (sample),
      .sample_stb_o (sample_stb)
   );

   // -------------------------------------------------------------------
   // Block acquisition and drain
   // -------------------------------------------------------------------
   block_buffer #(.AXNUM(AXNUM), .BBITS(BBITS)) buf0 (
      .clk_i     (clk_i),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   acq_control #(.AXNUM(AXNUM), .BBITS(BBITS)) ctrl0 (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .aq_ce_i        (aq_ce_i),
      .sample_stb_i   (sample_stb),
      .sample_i       (sample),
      .busy_i         (busy),
      .mem_full_i     (mem_full),
      .rd_req_i       (rd_req_i),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data),
      .blk_ready_o    (blk_ready),
      .blk_sel_o      (blk_sel),
      .fake_restart_o (fake_restart),
      .tart_state_o   (tart_state_o)
   );

   mcb_writer #(.AXNUM(AXNUM), .BBITS(BBITS), .ABITS(ABITS)) writer0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .blk_ready_i (blk_ready),
      .blk_sel_i   (blk_sel),
      .rd_data_i   (rd_data),
      .mcb_rdy_i   (mcb_rdy_i),
      .rd_req_i    (rd_req_i),
      .rd_addr_o   (rd_addr),
      .busy_o      (busy),
      .mem_full_o  (mem_full),
      .mcb_ce_o    (mcb_ce_o),
      .mcb_wr_o    (mcb_wr_o),
      .mcb_adr_o   (mcb_adr_o),
      .mcb_dat_o   (mcb_dat_o)
   );

endmodule

`default_nettype wire

/* src/mcb_writer.sv */
`default_nettype none

module mcb_writer #(
   parameter int AXNUM = 24,
   parameter int BBITS = 4,
   parameter int ABITS = 20
) (
   input  wire logic                        clk_i,
   input  wire logic                        rst_i,
   input  wire logic                        blk_ready_i,
   input  wire logic                        blk_sel_i,
   input  wire logic [AXNUM-1:0]            rd_data_i,
   input  wire logic                        mcb_rdy_i,
   input  wire logic                        rd_req_i,
   output logic      [BBITS:0]              rd_addr_o,
   output logic                             busy_o,
   output logic                             mem_full_o,
   output logic                             mcb_ce_o,
   output logic                             mcb_wr_o,
   output logic      [ABITS-1:0]            mcb_adr_o,
   output logic      [tart_pkg::MCB_DW-1:0] mcb_dat_o
);
   import tart_pkg::*;

   typedef enum logic [1:0] {
      W_IDLE,   // No block
      W_READ,   // Buffer read in progress
      W_WRITE   // Word on the memory port
   } wr_state_t;

   wr_state_t        wst_q;
   logic             sel_q;     // Half being drained
   logic [BBITS-1:0] idx_q;     // Word within block
   logic [ABITS:0]   adr_q;     // Extra MSB marks the region as full
   logic             start;
   logic             accept;

   assign start  = (wst_q == W_IDLE) && blk_ready_i && !adr_q[ABITS];
   assign accept = mcb_ce_o && mcb_rdy_i;  // Write completes

   // -------------------------------------------------------------------
   // Block drain, two clocks per word without back-pressure
   // -------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wst_q <= W_IDLE;
         idx_q <= '0;
      end else begin
         case (wst_q)
            W_IDLE: begin
               if (start) begin
                  wst_q <= W_READ;
                  idx_q <= '0;
               end
            end
            W_READ: wst_q <= W_WRITE;  // Data valid next cycle
            W_WRITE: begin
               if (accept) begin
                  idx_q <= idx_q + 1'b1;
                  wst_q <= (&idx_q) ? W_IDLE : W_READ;  // Last word ends block
               end
            end
            default: wst_q <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         sel_q <= blk_sel_i;
      end
   end

   // Memory address, cleared once the host has read the region
   always_ff @(posedge clk_i) begin
      if (rst_i || rd_req_i) begin
         adr_q <= '0;
      end else if (accept) begin
         adr_q <= adr_q + 1'b1;
      end
   end

   assign rd_addr_o  = {sel_q, idx_q};
   assign busy_o     = (wst_q != W_IDLE);
   assign mem_full_o = adr_q[ABITS];

   // Memory port
   assign mcb_ce_o  = (wst_q == W_WRITE);
   assign mcb_wr_o  = mcb_ce_o;             // Write-only port
   assign mcb_adr_o = adr_q[ABITS-1:0];
   assign mcb_dat_o = MCB_DW'(rd_data_i);  // Zero-extended sample

   // Stalled write holds the port, which needs the drained half untouched
   assert property (@(posedge clk_i) disable iff (rst_i)
      (mcb_ce_o && !mcb_rdy_i && !rd_req_i) |=>
         (mcb_ce_o && $stable(mcb_adr_o) && $stable(mcb_dat_o)))
      else $error("mcb_writer: memory port changed during a stalled write");

endmodule

`default_nettype wire

/* src/acq_control.sv */
`default_nettype none

module acq_control #(
   parameter int AXNUM = 24,
   parameter int BBITS = 4
) (
   input  wire logic             clk_i,
   input  wire logic             rst_i,
   input  wire logic             aq_ce_i,       // Acquisition enable level
   input  wire logic             sample_stb_i,
   input  wire logic [AXNUM-1:0] sample_i,
   input  wire logic             busy_i,        // Writer still draining
   input  wire logic             mem_full_i,
   input  wire logic             rd_req_i,      // Host has read memory
   output logic                  wr_en_o,
   output logic      [BBITS:0]   wr_addr_o,
   output logic      [AXNUM-1:0] wr_data_o,
   output logic                  blk_ready_o,
   output logic                  blk_sel_o,
   output logic                  fake_restart_o,
   output tart_pkg::tart_state_t tart_state_o
);
   import tart_pkg::*;

   tart_state_t    state_q;
   tart_state_t    state_d;
   logic [BBITS:0] wr_ptr_q;     // MSB is the half being filled
   logic           blk_last;     // Pointer at last word of a block
   logic           blk_done;     // Last word written this cycle
   logic           blk_ready_q;
   logic           blk_sel_q;

   // -------------------------------------------------------------------
   // Buffer write port
   // -------------------------------------------------------------------
   assign wr_en_o   = (state_q == ACQUIRE) && aq_ce_i && !mem_full_i && sample_stb_i;
   assign wr_addr_o = wr_ptr_q;
   assign wr_data_o = sample_i;

   assign blk_last = &wr_ptr_q[BBITS-1:0];
   assign blk_done = wr_en_o && blk_last;

   assign fake_restart_o = (state_q == IDLE) && aq_ce_i;  // Leaving IDLE

   // -------------------------------------------------------------------
   // State machine
   // -------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (aq_ce_i) begin
               state_d = ACQUIRE;
            end
         end
         ACQUIRE: begin
            if (!aq_ce_i) begin
               state_d = IDLE;      // Partial block is dropped
            end else if (mem_full_i) begin
               state_d = FULL;
            end else if (blk_done && busy_i) begin
               state_d = OVERFLOW;  // Previous block not yet drained
            end
         end
         FULL, OVERFLOW: begin
            if (rd_req_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= IDLE;
         wr_ptr_q    <= '0;
         blk_ready_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         blk_ready_q <= blk_done && !busy_i;  // Hand-off, next cycle
         if (fake_restart_o) begin
            wr_ptr_q[BBITS-1:0] <= '0;  // Restart block, keep the free half
         end else if (wr_en_o) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;  // Carry flips the half
         end
      end
   end

   // Half of the block just completed
   always_ff @(posedge clk_i) begin
      if (blk_done) begin
         blk_sel_q <= wr_ptr_q[BBITS];
      end
   end

   assign blk_ready_o  = blk_ready_q;
   assign blk_sel_o    = blk_sel_q;
   assign tart_state_o = state_q;

   // Hand-off only while acquiring, and only to an idle writer
   assert property (@(posedge clk_i) disable iff (rst_i)
      blk_ready_o |-> (state_q == ACQUIRE && !busy_i))
      else $error("acq_control: block hand-off outside ACQUIRE or to a busy writer");

endmodule

`default_nettype wire

/* src/block_buffer.sv */
`default_nettype none

module block_buffer #(
   parameter int AXNUM = 24,
   parameter int BBITS = 4   // Log2 of samples per block
) (
   input  wire logic             clk_i,
   input  wire logic             wr_en_i,
   input  wire logic [BBITS:0]   wr_addr_i,  // MSB picks ping or pong
   input  wire logic [AXNUM-1:0] wr_data_i,
   input  wire logic [BBITS:0]   rd_addr_i,
   output logic      [AXNUM-1:0] rd_data_o
);

   localparam int DEPTH = 2 ** (BBITS + 1);  // Two blocks

   logic [AXNUM-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // Read port, one clock of latency
   // Output follows the address every cycle
   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

/* src/capture_front.sv */
`default_nettype none

module capture_front #(
   parameter int AXNUM = 24
) (
   input  wire logic                            clk_i,
   input  wire logic                            rst_i,
   input  wire logic [AXNUM-1:0]                ax_data_i,   // Live antennas
   input  wire logic [AXNUM-1:0]                fake_i,      // Debug source
   input  wire logic                            aq_debug_i,
   input  wire logic [tart_pkg::PHASE_BITS-1:0] aq_delay_i,
   output logic      [AXNUM-1:0]                ax_data_o,
   output logic      [AXNUM-1:0]                sample_o,
   output logic                                 sample_stb_o
);
   import tart_pkg::*;

   localparam logic [PHASE_BITS-1:0] PHASE_MAX = PHASE_BITS'(SAMPLE_DIV - 1);

   logic [AXNUM-1:0]      ax_real_q;  // Input register
   logic [AXNUM-1:0]      ax_data_q;  // After source select
   logic [PHASE_BITS-1:0] phase_q;
   logic [PHASE_BITS-1:0] delay_sel;

   // -------------------------------------------------------------------
   // Data capture
   // -------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      ax_real_q <= ax_data_i;
      ax_data_q <= aq_debug_i ? fake_i : ax_real_q;  // Real path is two clocks
   end

   assign ax_data_o = ax_data_q;
   assign sample_o  = ax_data_q;  // Same word goes to the buffer

   // -------------------------------------------------------------------
   // Sample phase
   // -------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         phase_q <= '0;
      end else if (phase_q == PHASE_MAX) begin
         phase_q <= '0;  // Wrap at SAMPLE_DIV
      end else begin
         phase_q <= phase_q + 1'b1;
      end
   end

   // Delays past the last phase collapse onto it
   assign delay_sel = (aq_delay_i > PHASE_MAX) ? PHASE_MAX : aq_delay_i;

   assign sample_stb_o = (phase_q == delay_sel);  // One clock in SAMPLE_DIV

endmodule

`default_nettype wire

/* src/fake_antenna.sv */
`default_nettype none

module fake_antenna #(
   parameter int               AXNUM     = 24,
   parameter logic [AXNUM-1:0] FAKE_SEED = 'h00ace1
) (
   input  wire logic             clk_i,
   input  wire logic             rst_i,
   input  wire logic             step_i,     // Sample strobe
   input  wire logic             restart_i,  // Acquisition start
   output logic      [AXNUM-1:0] fake_o
);
   import tart_pkg::*;

   localparam logic [AXNUM-1:0] TAPS = AXNUM'(FAKE_TAPS);

   logic [AXNUM-1:0] lfsr_q;
   logic             feedback;

   assign feedback = ^(lfsr_q & TAPS);  // Fibonacci form, XOR of tapped bits

   always_ff @(posedge clk_i) begin
      if (rst_i || restart_i) begin
         lfsr_q <= FAKE_SEED;
      end else if (step_i) begin
         lfsr_q <= {lfsr_q[AXNUM-2:0], feedback};  // Shift up, new bit at LSB
      end
   end

   // Seed is visible already in the restart cycle, so the capture register
   // holds it for a strobe in the very next cycle
   assign fake_o = restart_i ? FAKE_SEED : lfsr_q;

   // All-zero state would lock the sequence
   assert property (@(posedge clk_i) disable iff (rst_i) lfsr_q != '0)
      else $error("fake_antenna: LFSR reached the all-zero state");

endmodule

`default_nettype wire

/* src/tart_pkg.sv */
`default_nettype none

package tart_pkg;

   // -------------------------------------------------------------------
   // Acquisition state, as seen on tart_state_o
   // -------------------------------------------------------------------
   typedef enum logic [2:0] {
      IDLE     = 3'd0,  // Waiting for aq_ce_i
      ACQUIRE  = 3'd1,  // Filling blocks
      FULL     = 3'd2,  // Memory region used up
      OVERFLOW = 3'd3   // Block done while writer still busy
   } tart_state_t;

   // -------------------------------------------------------------------
   // Sample divider
   // -------------------------------------------------------------------
   localparam int SAMPLE_DIV = 6;  // Clocks per sample
   localparam int PHASE_BITS = 3;  // Wide enough for 0..SAMPLE_DIV-1

   // Fake source polynomial x^24 + x^23 + x^22 + x^17 + 1
   // Taps at bits 24, 23, 22 and 17, counted from one
   localparam logic [23:0] FAKE_TAPS = 24'he1_0000;

   // Memory controller data bus
   localparam int MCB_DW = 32;

endpackage

`default_nettype wire
